//--- source/sg_cfg.svh
`ifndef SG_CFG_SVH
`define SG_CFG_SVH

// wishbone side
`define SG_ADDR_W    32                      // byte address width
`define SG_DAT_W     64                      // one beat, lo and hi word
`define SG_WORD_W    (`SG_DAT_W / 2)         // bus word, 32 bits

// descriptor layout, high word of beat 0
`define SG_LEN_W     16                      // length in 8-byte units
`define SG_LEN_LSB   3                       // len sits at [18:3]
`define SG_LAST_BIT  20                      // last flag

// pointers are 8-byte aligned
`define SG_PTR_LSB   3
`define SG_PTR_W     (`SG_ADDR_W - `SG_PTR_LSB) // 29 bit pointer

`define SG_CODE_W    2                       // panic code width

`endif

//--- source/sg_bus_pkg.sv
`include "sg_cfg.svh"

package sg_bus_pkg;

   // reply seen on the bus in one cycle
   typedef enum logic [1:0] {
      RSP_NONE  = 2'd0,                      // nothing yet, or cyc low
      RSP_ACK   = 2'd1,                      // beat accepted
      RSP_RETRY = 2'd2,                      // slave asks to try again
      RSP_ERROR = 2'd3                       // bus fault
   } bus_rsp_t;

   // where the walk failed
   typedef enum logic [`SG_CODE_W-1:0] {
      PANIC_NONE  = 2'd0,
      PANIC_DESC0 = 2'd1,                    // descriptor beat 0
      PANIC_DESC1 = 2'd2,                    // descriptor beat 1
      PANIC_BUF   = 2'd3                     // buffer read
   } panic_code_t;

endpackage

//--- source/sg_desc_pkg.sv
`include "sg_cfg.svh"

package sg_desc_pkg;

   // beat 0: hi word has last/len, lo word has buffer address
   typedef struct packed {
      logic [`SG_WORD_W-`SG_LAST_BIT-2:0]          rsvd_hi;  // [31:21]
      logic                                        last;     // [20]
      logic [`SG_LAST_BIT-`SG_LEN_LSB-`SG_LEN_W-1:0] gap;    // [19]
      logic [`SG_LEN_W-1:0]                        len;      // [18:3]
      logic [`SG_LEN_LSB-1:0]                      len_pad;  // [2:0]
      logic [`SG_PTR_W-1:0]                        addr;     // lo [31:3]
      logic [`SG_PTR_LSB-1:0]                      addr_pad; // lo [2:0]
   } desc_head_t;

   // beat 1: next pointer in hi word, lo word unused
   typedef struct packed {
      logic [`SG_PTR_W-1:0]   next;          // hi [31:3]
      logic [`SG_PTR_LSB-1:0] next_pad;
      logic [`SG_WORD_W-1:0]  rsvd_lo;
   } desc_link_t;

   // one bus beat, read as head or link by beat index
   typedef union packed {
      desc_head_t head;
      desc_link_t link;
   } desc_beat_u;

   typedef enum logic [2:0] {
      ST_IDLE     = 3'd0,
      ST_DESC_REQ = 3'd1,                    // reading descriptor
      ST_BUF_REQ  = 3'd2,                    // reading buffer
      ST_BUF_WAIT = 3'd3,                    // waiting on consumer ready
      ST_NEXT     = 3'd4,                    // pick next descriptor
      ST_END      = 3'd5,                    // chain finished
      ST_PANIC    = 3'd6                     // bus error seen
   } walk_state_t;

endpackage

//--- source/sg_ifs.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

// decode -> walker command path
interface sg_cmd_if;
   logic                 start;              // go strobe
   logic [`SG_PTR_W-1:0] first_ptr;          // first descriptor
   logic                 done;               // controller done strobe
   logic                 busy;               // walker not idle

   modport src (output start, first_ptr, done, input busy);
   modport snk (input start, first_ptr, done, output busy);
endinterface

// walker -> result beats and status
interface sg_beat_if;
   import sg_bus_pkg::*;
   import sg_desc_pkg::*;

   logic                 beat_vld;           // acked buffer beat
   logic [`SG_DAT_W-1:0] beat_dat;
   logic                 walk_end;           // entering end
   logic                 panic;              // entering panic
   panic_code_t          panic_code;         // valid with panic
   walk_state_t          state;
   logic                 last;
   logic [`SG_LEN_W-1:0] len;                // beats left in buffer

   modport src (output beat_vld, beat_dat, walk_end, panic, panic_code, state, last, len);
   modport snk (input beat_vld, beat_dat, walk_end, panic, panic_code, state, last, len);
endinterface

//--- source/sg_cmd_decode.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

module sg_cmd_decode (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  cmd_we_i,    // register write strobe
   input  logic [1:0]            cmd_adr_i,   // register index
   input  logic [`SG_ADDR_W-1:0] cmd_dat_i,
   input  logic                  cmd_done_i,  // controller done
   sg_cmd_if.src                 cmd
);

   localparam logic [1:0] ADR_PTR = 2'd2;     // first descriptor pointer
   localparam logic [1:0] ADR_GO  = 2'd3;     // start walk

   logic [`SG_PTR_W-1:0] ptr_q;               // first descriptor, no reset
   logic                 start_q;
   logic                 done_prev_q;         // done input last cycle
   logic                 done_q;
   logic                 go_hit;

   // start only when walker idle and nothing already pending
   assign go_hit = cmd_we_i && (cmd_adr_i == ADR_GO) && !cmd.busy && !start_q;

   always_ff @(posedge wb_clk_i) begin
      if (cmd_we_i && (cmd_adr_i == ADR_PTR)) begin
         ptr_q <= cmd_dat_i[`SG_ADDR_W-1:`SG_PTR_LSB]; // drop the low 3 bits
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         start_q     <= 1'b0;
         done_prev_q <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         start_q     <= go_hit;               // one cycle after the write
         done_prev_q <= cmd_done_i;
         done_q      <= cmd_done_i && !done_prev_q; // rising edge only
      end
   end

   assign cmd.start     = start_q;
   assign cmd.first_ptr = ptr_q;
   assign cmd.done      = done_q;

endmodule

//--- source/sg_walker.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

module sg_walker (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   output logic                  wbm_cyc_o,
   output logic                  wbm_stb_o,
   output logic [`SG_ADDR_W-1:0] wbm_adr_o,
   input  logic [`SG_WORD_W-1:0] wbm_dat_lo_i,
   input  logic [`SG_WORD_W-1:0] wbm_dat_hi_i,
   input  logic                  wbm_ack_i,
   input  logic                  wbm_rty_i,
   input  logic                  wbm_err_i,
   input  logic                  rdy_i,        // consumer can take beats
   sg_cmd_if.snk                 cmd,
   sg_beat_if.src                beat
);
   import sg_bus_pkg::*;
   import sg_desc_pkg::*;

   walk_state_t          state_q, state_n;
   logic                 req_q, req_n;        // cyc and stb together
   logic                 cnt_q, cnt_n;        // descriptor beat index
   logic                 io_q, io_n;          // a beat acked this cycle
   logic                 last_q, last_n;
   logic [`SG_LEN_W-1:0] len_q, len_n;        // beats left
   logic [`SG_PTR_W-1:0] buf_ptr, buf_n;      // buffer address
   logic [`SG_PTR_W-1:0] next_ptr, next_n;    // descriptor address
   bus_rsp_t             rsp;
   panic_code_t          fail_code;
   desc_beat_u           desc_w;

   assign desc_w = {wbm_dat_hi_i, wbm_dat_lo_i};  // head or link by cnt_q

   // reply decode, error wins, ignored with no cycle out
   always_comb begin
      if (!req_q)          rsp = RSP_NONE;
      else if (wbm_err_i)  rsp = RSP_ERROR;
      else if (wbm_rty_i)  rsp = RSP_RETRY;
      else if (wbm_ack_i)  rsp = RSP_ACK;
      else                 rsp = RSP_NONE;
   end

   always_comb begin
      case (state_q)
         ST_DESC_REQ: fail_code = cnt_q ? PANIC_DESC1 : PANIC_DESC0;
         ST_BUF_REQ:  fail_code = PANIC_BUF;
         default:     fail_code = PANIC_NONE;
      endcase
   end

   always_comb begin
      state_n = state_q;
      req_n   = req_q;
      cnt_n   = cnt_q;
      io_n    = io_q;
      last_n  = last_q;
      len_n   = len_q;
      buf_n   = buf_ptr;
      next_n  = next_ptr;
      case (state_q)
         ST_IDLE: begin
            if (cmd.start) begin
               state_n = ST_DESC_REQ;
               req_n   = 1'b1;                // bus up with the state change
               cnt_n   = 1'b0;
               last_n  = 1'b0;
               next_n  = cmd.first_ptr;
            end
         end
         ST_DESC_REQ: begin
            case (rsp)
               RSP_ACK: begin
                  if (!cnt_q) begin
                     len_n  = desc_w.head.len;
                     last_n = desc_w.head.last;
                     buf_n  = desc_w.head.addr;
                     next_n = next_ptr + 1'b1; // beat 1 is 8 bytes on
                     cnt_n  = 1'b1;
                  end else begin
                     next_n  = desc_w.link.next;
                     req_n   = 1'b0;
                     state_n = (len_q == '0) ? ST_NEXT : ST_BUF_WAIT; // empty buffer
                  end
               end
               RSP_ERROR: begin
                  req_n   = 1'b0;
                  state_n = ST_PANIC;
               end
               default: ;                     // retry just holds the request
            endcase
         end
         ST_BUF_WAIT: begin
            if (rdy_i) begin
               state_n = ST_BUF_REQ;
               req_n   = 1'b1;
               io_n    = 1'b0;
            end
         end
         ST_BUF_REQ: begin
            case (rsp)
               RSP_ACK: begin
                  buf_n = buf_ptr + 1'b1;
                  len_n = len_q - 1'b1;
                  io_n  = 1'b1;
                  if (len_q == `SG_LEN_W'(1)) begin // final beat of buffer
                     req_n   = 1'b0;
                     state_n = ST_NEXT;
                  end
               end
               RSP_RETRY: begin
                  if (io_q) begin             // drop cycle, wait for ready
                     req_n   = 1'b0;
                     state_n = ST_BUF_WAIT;
                  end
               end
               RSP_ERROR: begin
                  req_n   = 1'b0;
                  state_n = ST_PANIC;
               end
               default: ;
            endcase
         end
         ST_NEXT: begin
            if (last_q) begin
               state_n = ST_END;
            end else begin
               state_n = ST_DESC_REQ;
               req_n   = 1'b1;
               cnt_n   = 1'b0;
            end
         end
         ST_END, ST_PANIC: begin
            if (cmd.done) state_n = ST_IDLE;  // both wait on controller
         end
         default: state_n = ST_IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q <= ST_IDLE;
         req_q   <= 1'b0;
         cnt_q   <= 1'b0;
         io_q    <= 1'b0;
         last_q  <= 1'b0;
         len_q   <= '0;
      end else begin
         state_q <= state_n;
         req_q   <= req_n;
         cnt_q   <= cnt_n;
         io_q    <= io_n;
         last_q  <= last_n;
         len_q   <= len_n;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      buf_ptr  <= buf_n;
      next_ptr <= next_n;
   end

   assign wbm_cyc_o = req_q;
   assign wbm_stb_o = req_q;                  // one beat outstanding at a time
   assign wbm_adr_o = {(state_q == ST_DESC_REQ) ? next_ptr : buf_ptr, `SG_PTR_LSB'(0)};

   assign cmd.busy = (state_q != ST_IDLE);

   assign beat.beat_vld   = (state_q == ST_BUF_REQ) && (rsp == RSP_ACK);
   assign beat.beat_dat   = desc_w;           // raw data beat
   assign beat.walk_end   = (state_q == ST_NEXT) && last_q;
   assign beat.panic      = (rsp == RSP_ERROR);
   assign beat.panic_code = fail_code;
   assign beat.state      = state_q;
   assign beat.last       = last_q;
   assign beat.len        = len_q;

endmodule

//--- source/sg_result.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

module sg_result (
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   sg_beat_if.snk                 beat,
   output logic                   xfer_o,      // one per acked beat
   output logic [`SG_DAT_W-1:0]   xfer_dat_o,
   output logic                   done_o,      // walk finished strobe
   output logic                   err_o,       // sticky until done
   output sg_bus_pkg::panic_code_t err_code_o,
   output logic [7:0]             dbg_state_o, // {last, 0000, state}
   output logic [`SG_LEN_W-1:0]   dbg_len_o
);
   import sg_bus_pkg::*;
   import sg_desc_pkg::*;

   logic [`SG_DAT_W-1:0] dat_q;               // payload, no reset

   always_ff @(posedge wb_clk_i) begin
      if (beat.beat_vld) dat_q <= beat.beat_dat;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         xfer_o      <= 1'b0;
         done_o      <= 1'b0;
         err_o       <= 1'b0;
         err_code_o  <= PANIC_NONE;
         dbg_state_o <= '0;
         dbg_len_o   <= '0;
      end else begin
         xfer_o <= beat.beat_vld;
         done_o <= beat.walk_end;             // first cycle of end
         if (beat.panic) begin
            err_o      <= 1'b1;
            err_code_o <= beat.panic_code;    // keep the failure point
         end else if (err_o && (beat.state == ST_IDLE)) begin
            err_o      <= 1'b0;               // walker left panic on done
            err_code_o <= PANIC_NONE;
         end
         dbg_state_o <= {beat.last, 4'h0, beat.state};
         dbg_len_o   <= beat.len;
      end
   end

   assign xfer_dat_o = dat_q;

endmodule

//--- source/sg_reader_top.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

module sg_reader_top (
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   // command registers from the DMA controller
   input  logic                    cmd_we_i,
   input  logic [1:0]              cmd_adr_i,
   input  logic [`SG_ADDR_W-1:0]   cmd_dat_i,
   input  logic                    cmd_done_i,
   // wishbone master, read only
   output logic                    wbm_cyc_o,
   output logic                    wbm_stb_o,
   output logic [`SG_ADDR_W-1:0]   wbm_adr_o,
   input  logic [`SG_WORD_W-1:0]   wbm_dat_lo_i,
   input  logic [`SG_WORD_W-1:0]   wbm_dat_hi_i,
   input  logic                    wbm_ack_i,
   input  logic                    wbm_rty_i,
   input  logic                    wbm_err_i,
   // consumer side
   input  logic                    rdy_i,
   output logic                    xfer_o,
   output logic [`SG_DAT_W-1:0]    xfer_dat_o,
   // status
   output logic                    done_o,
   output logic                    err_o,
   output sg_bus_pkg::panic_code_t err_code_o,
   output logic [7:0]              dbg_state_o,
   output logic [`SG_LEN_W-1:0]    dbg_len_o
);

   sg_cmd_if  cmd_if ();                      // decode to walker
   sg_beat_if beat_if ();                     // walker to result

   sg_cmd_decode sg_cmd_decode_i (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .cmd_we_i   (cmd_we_i),
      .cmd_adr_i  (cmd_adr_i),
      .cmd_dat_i  (cmd_dat_i),
      .cmd_done_i (cmd_done_i),
      .cmd        (cmd_if.src)
   );

   sg_walker sg_walker_i (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .wbm_cyc_o    (wbm_cyc_o),
      .wbm_stb_o    (wbm_stb_o),
      .wbm_adr_o    (wbm_adr_o),
      .wbm_dat_lo_i (wbm_dat_lo_i),
      .wbm_dat_hi_i (wbm_dat_hi_i),
      .wbm_ack_i    (wbm_ack_i),
      .wbm_rty_i    (wbm_rty_i),
      .wbm_err_i    (wbm_err_i),
      .rdy_i        (rdy_i),
      .cmd          (cmd_if.snk),
      .beat         (beat_if.src)
   );

   sg_result sg_result_i (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .beat        (beat_if.snk),
      .xfer_o      (xfer_o),
      .xfer_dat_o  (xfer_dat_o),
      .done_o      (done_o),
      .err_o       (err_o),
      .err_code_o  (err_code_o),
      .dbg_state_o (dbg_state_o),
      .dbg_len_o   (dbg_len_o)
   );

endmodule

//--- dv/sg_mem_model.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

// wishbone read slave, replies one cycle after the strobe
module sg_mem_model (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic [`SG_ADDR_W-1:0] adr_i,
   output logic [`SG_WORD_W-1:0] dat_lo_o,
   output logic [`SG_WORD_W-1:0] dat_hi_o,
   output logic                  ack_o,
   output logic                  rty_o,
   output logic                  err_o
);

   logic [`SG_DAT_W-1:0] mem [int unsigned];      // sparse, one entry per 8 bytes
   bit                   rty_set [int unsigned];  // retry once at this beat
   bit                   rty_done [int unsigned]; // retry already handed out
   bit                   err_set [int unsigned];  // error reply at this beat
   int unsigned          key;                     // beat index of adr_i
   int                   rty_cnt;                 // retries handed out so far

   assign key = adr_i >> `SG_PTR_LSB;

   task automatic write_word(input logic [`SG_ADDR_W-1:0] addr,
                             input logic [`SG_DAT_W-1:0] data);
      mem[addr >> `SG_PTR_LSB] = data;
   endtask

   task automatic set_retry(input logic [`SG_ADDR_W-1:0] addr);
      rty_set[addr >> `SG_PTR_LSB] = 1'b1;
   endtask

   task automatic set_error(input logic [`SG_ADDR_W-1:0] addr);
      err_set[addr >> `SG_PTR_LSB] = 1'b1;
   endtask

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o    <= 1'b0;
         rty_o    <= 1'b0;
         err_o    <= 1'b0;
         dat_lo_o <= '0;
         dat_hi_o <= '0;
         rty_cnt  <= 0;
      end else begin
         ack_o <= 1'b0;                       // replies are single cycle
         rty_o <= 1'b0;
         err_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o && !rty_o && !err_o) begin
            if (err_set.exists(key)) begin
               err_o <= 1'b1;
            end else if (rty_set.exists(key) && !rty_done.exists(key)) begin
               rty_o         <= 1'b1;
               rty_done[key] = 1'b1;          // next try gets the ack
               rty_cnt       <= rty_cnt + 1;
            end else begin
               ack_o <= 1'b1;
               // unwritten beats read back an address pattern
               {dat_hi_o, dat_lo_o} <= mem.exists(key) ? mem[key] : {~adr_i, adr_i};
            end
         end
      end
   end

endmodule

//--- dv/sg_reader_tb.sv
`timescale 1ns/1ps
`include "sg_cfg.svh"

module sg_reader_tb;
   import sg_bus_pkg::*;
   import sg_desc_pkg::*;

   localparam int TOTAL_BEATS = 4 + 5 + 6 + 0 + 8;  // beats over all five tests
   localparam int TIMEOUT     = TOTAL_BEATS * 8 + 200;

   logic                  wb_clk_i = 1'b0;
   logic                  wb_rst_i;
   logic                  cmd_we_i;
   logic [1:0]            cmd_adr_i;
   logic [`SG_ADDR_W-1:0] cmd_dat_i;
   logic                  cmd_done_i;
   logic                  rdy_i;
   logic                  wbm_cyc;
   logic                  wbm_stb;
   logic [`SG_ADDR_W-1:0] wbm_adr;
   logic [`SG_WORD_W-1:0] wbm_dat_lo;
   logic [`SG_WORD_W-1:0] wbm_dat_hi;
   logic                  wbm_ack;
   logic                  wbm_rty;
   logic                  wbm_err;
   logic                  xfer_o;
   logic [`SG_DAT_W-1:0]  xfer_dat_o;
   logic                  done_o;
   logic                  err_o;
   panic_code_t           err_code_o;
   logic [7:0]            dbg_state_o;
   logic [`SG_LEN_W-1:0]  dbg_len_o;

   integer                seed;
   int                    err_cnt = 0;       // mismatches over the run
   int                    pass_cnt = 0;
   int                    fail_cnt = 0;
   int                    err_base;          // err_cnt when the test began
   int                    done_cnt = 0;      // done_o strobes seen
   int                    done_base;
   int                    got_base;          // first beat of this test
   int                    cycles = 0;
   logic [`SG_DAT_W-1:0]  got_q [$];         // every transfer seen
   logic [`SG_DAT_W-1:0]  exp_q [$];         // beats this test expects

   always #10 wb_clk_i = ~wb_clk_i;          // 20 ns period

   sg_reader_top sg_reader_top_i (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .cmd_we_i     (cmd_we_i),
      .cmd_adr_i    (cmd_adr_i),
      .cmd_dat_i    (cmd_dat_i),
      .cmd_done_i   (cmd_done_i),
      .wbm_cyc_o    (wbm_cyc),
      .wbm_stb_o    (wbm_stb),
      .wbm_adr_o    (wbm_adr),
      .wbm_dat_lo_i (wbm_dat_lo),
      .wbm_dat_hi_i (wbm_dat_hi),
      .wbm_ack_i    (wbm_ack),
      .wbm_rty_i    (wbm_rty),
      .wbm_err_i    (wbm_err),
      .rdy_i        (rdy_i),
      .xfer_o       (xfer_o),
      .xfer_dat_o   (xfer_dat_o),
      .done_o       (done_o),
      .err_o        (err_o),
      .err_code_o   (err_code_o),
      .dbg_state_o  (dbg_state_o),
      .dbg_len_o    (dbg_len_o)
   );

   sg_mem_model mem_i (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc_i    (wbm_cyc),
      .stb_i    (wbm_stb),
      .adr_i    (wbm_adr),
      .dat_lo_o (wbm_dat_lo),
      .dat_hi_o (wbm_dat_hi),
      .ack_o    (wbm_ack),
      .rty_o    (wbm_rty),
      .err_o    (wbm_err)
   );

   // outputs settle after the rising edge, so look at them on the falling one
   always @(negedge wb_clk_i) begin
      if (xfer_o) got_q.push_back(xfer_dat_o);
      if (done_o) done_cnt++;
   end

   always @(posedge wb_clk_i) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("error: %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic begin_test();
      err_base  = err_cnt;
      done_base = done_cnt;
      got_base  = got_q.size();
      exp_q.delete();
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_base) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d mismatches", name, err_cnt - err_base);
      end
   endtask

   // beat 0 hi word = {rsvd, last[20], gap, len[18:3], pad}, lo = buffer address
   task automatic put_desc(input logic [31:0] addr, input logic [31:0] buf_addr,
                           input logic [15:0] len, input logic last,
                           input logic [31:0] next);
      mem_i.write_word(addr, {11'd0, last, 1'b0, len, 3'b000, buf_addr});
      mem_i.write_word(addr + 32'd8, {next, 32'h0}); // link in hi word
   endtask

   task automatic fill_buf(input logic [31:0] addr, input int len);
      logic [63:0] w;
      int i;
      for (i = 0; i < len; i++) begin
         w = {$random(seed), $random(seed)};
         mem_i.write_word(addr + 32'(i * 8), w);
         exp_q.push_back(w);                  // chain order = fill order
      end
   endtask

   task automatic reg_write(input logic [1:0] adr, input logic [31:0] dat);
      @(negedge wb_clk_i);
      cmd_we_i  = 1'b1;
      cmd_adr_i = adr;
      cmd_dat_i = dat;
      @(negedge wb_clk_i);
      cmd_we_i  = 1'b0;
   endtask

   task automatic pulse_done();
      @(negedge wb_clk_i);
      cmd_done_i = 1'b1;
      @(negedge wb_clk_i);
      cmd_done_i = 1'b0;
      repeat (4) @(negedge wb_clk_i);         // walker back in idle, status cleared
   endtask

   task automatic wait_end();
      do begin
         @(negedge wb_clk_i);
      end while (!done_o && !err_o);
      repeat (2) @(negedge wb_clk_i);
   endtask

   task automatic wait_state(input walk_state_t s);
      do begin
         @(negedge wb_clk_i);
      end while (dbg_state_o[2:0] != s);
   endtask

   task automatic count_cyc(input int len, output int n);
      n = 0;
      repeat (len) begin
         @(negedge wb_clk_i);
         if (wbm_cyc) n++;
      end
   endtask

   task automatic check_beats();
      int n;
      int i;
      n = got_q.size() - got_base;
      check_val("xfer_o count", 64'(n), 64'(exp_q.size()));
      if (n > exp_q.size()) n = exp_q.size();
      for (i = 0; i < n; i++) begin
         check_val("xfer_dat_o", got_q[got_base + i], exp_q[i]);
      end
   endtask

   task automatic single_desc();
      begin_test();
      put_desc(32'h1000, 32'h2000, 16'd4, 1'b1, 32'h0);
      fill_buf(32'h2000, 4);
      reg_write(2'd2, 32'h1000);
      reg_write(2'd3, 32'h0);
      wait_end();
      pulse_done();
      check_beats();
      check_val("done_o count", 64'(done_cnt - done_base), 64'd1);
      end_test("single descriptor");
   endtask

   task automatic desc_chain();
      begin_test();
      put_desc(32'h1100, 32'h3000, 16'd2, 1'b0, 32'h1200);
      put_desc(32'h1200, 32'h3800, 16'd0, 1'b0, 32'h1300); // empty, no beats
      put_desc(32'h1300, 32'h4000, 16'd3, 1'b1, 32'h0);
      fill_buf(32'h3000, 2);
      fill_buf(32'h4000, 3);
      reg_write(2'd2, 32'h1100);
      reg_write(2'd3, 32'h0);
      wait_end();
      pulse_done();
      check_beats();
      check_val("done_o count", 64'(done_cnt - done_base), 64'd1);
      end_test("three descriptor chain");
   endtask

   task automatic ready_retry();
      int busy_cyc;
      int rty0;
      begin_test();
      put_desc(32'h1400, 32'h5000, 16'd6, 1'b1, 32'h0);
      fill_buf(32'h5000, 6);
      mem_i.set_retry(32'h5010);              // third beat, after two acks
      rty0  = mem_i.rty_cnt;
      rdy_i = 1'b0;
      reg_write(2'd2, 32'h1400);
      reg_write(2'd3, 32'h0);
      wait_state(ST_BUF_WAIT);
      count_cyc(12, busy_cyc);
      check_val("wbm_cyc_o count", 64'(busy_cyc), 64'd0);
      check_val("xfer_o count", 64'(got_q.size() - got_base), 64'd0);
      check_val("dbg_len_o", 64'(dbg_len_o), 64'd6);      // whole buffer left
      check_val("dbg_state_o", 64'(dbg_state_o), 64'h83); // last set, buffer wait
      rdy_i = 1'b1;
      wait_end();
      pulse_done();
      check_beats();
      check_val("wbm_rty_i count", 64'(mem_i.rty_cnt - rty0), 64'd1);
      end_test("ready and retry");
   endtask

   task automatic desc_bus_error();
      begin_test();
      put_desc(32'h1500, 32'h6000, 16'd2, 1'b1, 32'h0);
      mem_i.set_error(32'h1508);              // link beat fails
      reg_write(2'd2, 32'h1500);
      reg_write(2'd3, 32'h0);
      wait_end();
      check_val("err_o", 64'(err_o), 64'd1);
      check_val("err_code_o", 64'(err_code_o), 64'(PANIC_DESC1));
      pulse_done();
      check_beats();                          // nothing expected
      check_val("done_o count", 64'(done_cnt - done_base), 64'd0);
      check_val("err_o", 64'(err_o), 64'd0);
      check_val("dbg_state_o", 64'(dbg_state_o[2:0]), 64'(ST_IDLE));
      end_test("descriptor bus error");
   endtask

   task automatic busy_writes();
      int idle_cyc;
      int i;
      begin_test();
      put_desc(32'h1600, 32'h7000, 16'd4, 1'b1, 32'h0);
      fill_buf(32'h7000, 4);
      rdy_i = 1'b0;                           // park the walk in buffer wait
      reg_write(2'd2, 32'h1600);
      reg_write(2'd3, 32'h0);
      wait_state(ST_BUF_WAIT);
      reg_write(2'd3, 32'h0);                 // walker busy
      rdy_i = 1'b1;
      wait_end();
      pulse_done();
      reg_write(2'd0, 32'hffff_ffff);         // unused registers, walker idle
      reg_write(2'd1, 32'h0000_0040);
      count_cyc(6, idle_cyc);                 // no walk starts
      check_val("wbm_cyc_o count", 64'(idle_cyc), 64'd0);
      for (i = 0; i < 4; i++) begin
         exp_q.push_back(exp_q[i]);           // same buffer read again
      end
      reg_write(2'd3, 32'h0);                 // pointer still at 0x1600
      wait_end();
      pulse_done();
      check_beats();
      check_val("done_o count", 64'(done_cnt - done_base), 64'd2);
      end_test("writes while busy");
   endtask

   initial begin
      seed       = 13970;
      wb_rst_i   = 1'b1;
      cmd_we_i   = 1'b0;
      cmd_adr_i  = 2'd0;
      cmd_dat_i  = '0;
      cmd_done_i = 1'b0;
      rdy_i      = 1'b1;
      repeat (3) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      single_desc();
      desc_chain();
      ready_retry();
      desc_bus_error();
      busy_writes();
      $display("summary: %0d tests ok, %0d tests bad, %0d mismatches",
               pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
+incdir+source
source/sg_bus_pkg.sv
source/sg_desc_pkg.sv
source/sg_ifs.sv
source/sg_cmd_decode.sv
source/sg_walker.sv
source/sg_result.sv
source/sg_reader_top.sv
dv/sg_mem_model.sv
dv/sg_reader_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/1ps
TOP       ?= sg_reader_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
